//--- cpu_pkg.sv
// shared core types; addresses are pc_w bits wide, so memory depths above 1024 words are not reachable
package cpu_pkg;

    localparam int xlen       = 32;
    localparam int pc_w       = 10;
    localparam int reg_addr_w = 5;
    localparam logic [reg_addr_w-1:0] link_reg = 5'd3; // return address register for jal

    typedef enum logic [5:0] {
        op_rtype = 6'd0,
        op_addi  = 6'd1,
        op_andi  = 6'd2,
        op_ori   = 6'd3,
        op_xori  = 6'd4,
        op_lw    = 6'd7,
        op_sw    = 6'd8,
        op_slti  = 6'd9,
        op_seq   = 6'd10,
        op_lui   = 6'd11,
        op_beq   = 6'd16,
        op_bne   = 6'd17,
        op_bgt   = 6'd18,
        op_bge   = 6'd19,
        op_blt   = 6'd20,
        op_ble   = 6'd21,
        op_j     = 6'd24,
        op_jal   = 6'd26
    } opcode_e;

    typedef enum logic [4:0] {
        alu_add, alu_sub, alu_and, alu_xor, alu_or, alu_not, alu_sll, alu_srl,
        alu_sne, alu_seq, alu_slt, alu_sle, alu_sgt, alu_sge, alu_lui,
        alu_mul_lo, alu_mul_hi, alu_bad
    } alu_op_e;

    // func field of R-type words
    localparam logic [5:0] fn_add    = 6'd0;
    localparam logic [5:0] fn_sub    = 6'd1;
    localparam logic [5:0] fn_and    = 6'd2;
    localparam logic [5:0] fn_or     = 6'd3;
    localparam logic [5:0] fn_not    = 6'd4;
    localparam logic [5:0] fn_xor    = 6'd5;
    localparam logic [5:0] fn_slt    = 6'd8;
    localparam logic [5:0] fn_sll    = 6'd9;
    localparam logic [5:0] fn_srl    = 6'd10;
    localparam logic [5:0] fn_mul_hi = 6'd11;
    localparam logic [5:0] fn_mul_lo = 6'd12;

    typedef struct packed {
        opcode_e                opcode;
        logic [reg_addr_w-1:0] dst;
        logic [reg_addr_w-1:0] src_a;
        logic [reg_addr_w-1:0] src_b;
        logic [4:0]            shamt;
        logic [5:0]            func;
    } r_fmt_t;

    typedef struct packed {
        opcode_e                opcode;
        logic [reg_addr_w-1:0] dst;   // second source for sw and branches
        logic [reg_addr_w-1:0] src_a;
        logic [15:0]           imm;
    } i_fmt_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [25:0] target;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fields;
        i_fmt_t i_fields;
        j_fmt_t j_fields;
    } instr_u;

    typedef struct packed {
        logic reg_write;
        logic mem_write;
        logic use_imm;
        logic mem_to_reg;
        logic branch;
        logic jump;
        logic link;
        logic b_from_dst;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic            to_data; // 0 imem, 1 dmem
        logic [pc_w-1:0] addr;
        logic [xlen-1:0] data;
    } load_req_t;

endpackage

//--- word_mem.sv
// contents are not initialised and not cleared by reset; a read in the write cycle returns the old word
`timescale 1ns/1ps

module word_mem import cpu_pkg::*; #(
    parameter int depth = 1024
) (
    input  logic            clk,
    input  logic            we,
    input  logic [pc_w-1:0] waddr,
    input  logic [xlen-1:0] wdata,
    input  logic [pc_w-1:0] raddr,
    output logic [xlen-1:0] rdata
);

    logic [xlen-1:0] mem [depth];

    // async read port
    assign rdata = mem[raddr];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata; // lands at this edge
        end
    end

endmodule

//--- reg_file.sv
// register 0 is writable like any other; reads during a write return the previous value
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [reg_addr_w-1:0] a_idx,
    input  logic [reg_addr_w-1:0] b_idx,
    input  logic [reg_addr_w-1:0] w_idx,
    input  logic                  we,
    input  logic [xlen-1:0]       wdata,
    output logic [xlen-1:0]       a_data,
    output logic [xlen-1:0]       b_data
);

    logic [xlen-1:0] regs [32];

    assign a_data = regs[a_idx];
    assign b_data = regs[b_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[w_idx] <= wdata;
        end
    end

endmodule

//--- alu.sv
// purely combinational; compares are signed and srl is logical, unknown ops return 32'hdeadbeef
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  logic [4:0]      shamt,
    input  alu_op_e         op,
    output logic [xlen-1:0] result
);

    logic signed [2*xlen-1:0] product;
    logic                     eq;
    logic                     lt;

    assign product = $signed(a) * $signed(b); // full 64-bit signed product
    assign eq      = (a == b);
    assign lt      = ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_xor:    result = a ^ b;
            alu_or:     result = a | b;
            alu_not:    result = ~a;
            alu_sll:    result = a << shamt;
            alu_srl:    result = a >> shamt;
            alu_sne:    result = {{(xlen-1){1'b0}}, !eq};
            alu_seq:    result = {{(xlen-1){1'b0}}, eq};
            alu_slt:    result = {{(xlen-1){1'b0}}, lt};
            alu_sle:    result = {{(xlen-1){1'b0}}, lt | eq};
            alu_sgt:    result = {{(xlen-1){1'b0}}, !(lt | eq)};
            alu_sge:    result = {{(xlen-1){1'b0}}, !lt};
            alu_lui:    result = b << 16; // b is the extended immediate here
            alu_mul_lo: result = product[xlen-1:0];
            alu_mul_hi: result = product[2*xlen-1:xlen];
            default:    result = 32'hdeadbeef;
        endcase
    end

endmodule

//--- decoder.sv
// control flags are forced to zero while rst is high; unlisted opcodes decode as no-ops
`timescale 1ns/1ps

module decoder import cpu_pkg::*; (
    input  logic    rst,
    input  instr_u  instr,
    output ctrl_t   ctrl,
    output alu_op_e alu_op
);

    // control flags per opcode group
    always_comb begin
        ctrl = '0;
        if (!rst) begin
            case (instr.r_fields.opcode)
                op_rtype: begin
                    ctrl.reg_write = 1'b1;
                end
                op_addi, op_andi, op_ori, op_xori, op_slti, op_seq, op_lui: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.use_imm   = 1'b1;
                end
                op_lw: begin
                    ctrl.reg_write  = 1'b1;
                    ctrl.use_imm    = 1'b1;
                    ctrl.mem_to_reg = 1'b1;
                end
                op_sw: begin
                    ctrl.mem_write  = 1'b1;
                    ctrl.use_imm    = 1'b1;
                    ctrl.b_from_dst = 1'b1; // store data comes from dst
                end
                op_beq, op_bne, op_bgt, op_bge, op_blt, op_ble: begin
                    ctrl.branch     = 1'b1;
                    ctrl.b_from_dst = 1'b1;
                end
                op_j: begin
                    ctrl.jump = 1'b1;
                end
                op_jal: begin
                    ctrl.jump      = 1'b1;
                    ctrl.link      = 1'b1;
                    ctrl.reg_write = 1'b1;
                end
                default: ctrl = '0;
            endcase
        end
    end

    // alu operation, from func for R-type
    always_comb begin
        case (instr.r_fields.opcode)
            op_rtype: begin
                case (instr.r_fields.func)
                    fn_add:    alu_op = alu_add;
                    fn_sub:    alu_op = alu_sub;
                    fn_and:    alu_op = alu_and;
                    fn_or:     alu_op = alu_or;
                    fn_not:    alu_op = alu_not;
                    fn_xor:    alu_op = alu_xor;
                    fn_slt:    alu_op = alu_slt;
                    fn_sll:    alu_op = alu_sll;
                    fn_srl:    alu_op = alu_srl;
                    fn_mul_hi: alu_op = alu_mul_hi;
                    fn_mul_lo: alu_op = alu_mul_lo;
                    default:   alu_op = alu_bad;
                endcase
            end
            op_addi, op_lw, op_sw: alu_op = alu_add; // address is src_a + imm
            op_andi: alu_op = alu_and;
            op_ori:  alu_op = alu_or;
            op_xori: alu_op = alu_xor;
            op_slti: alu_op = alu_slt;
            op_seq:  alu_op = alu_seq;
            op_lui:  alu_op = alu_lui;
            // branches yield the taken bit in result[0]
            op_beq:  alu_op = alu_seq;
            op_bne:  alu_op = alu_sne;
            op_bgt:  alu_op = alu_sgt;
            op_bge:  alu_op = alu_sge;
            op_blt:  alu_op = alu_slt;
            op_ble:  alu_op = alu_sle;
            default: alu_op = alu_bad;
        endcase
    end

endmodule

//--- pc_unit.sv
// word-addressed PC that wraps modulo 1024; a jump takes priority over a branch
`timescale 1ns/1ps

module pc_unit import cpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            jump,
    input  logic            branch,
    input  logic            taken,
    input  logic [pc_w-1:0] target,
    input  logic [15:0]     offset,
    output logic [pc_w-1:0] pc
);

    logic [pc_w-1:0] pc_seq;

    assign pc_seq = pc + pc_w'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (jump) begin
            pc <= target;
        end else if (branch && taken) begin
            pc <= pc_seq + offset[pc_w-1:0]; // offset relative to PC+1
        end else begin
            pc <= pc_seq;
        end
    end

endmodule

//--- cpu_top.sv
// single-cycle core; load port has no back-pressure and should be used while rst is high
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
    parameter int mem_depth = 1024
) (
    input  logic            clk,
    input  logic            rst,
    input  load_req_t       load,
    output logic [xlen-1:0] a_data
);

    logic [pc_w-1:0]       pc;
    logic [pc_w-1:0]       pc_plus1;
    logic [xlen-1:0]       imem_rdata;
    instr_u                instr;
    ctrl_t                 ctrl;
    alu_op_e               alu_op;
    logic [xlen-1:0]       imm_ext;
    logic [reg_addr_w-1:0] b_idx;
    logic [reg_addr_w-1:0] w_idx;
    logic [xlen-1:0]       b_data;
    logic [xlen-1:0]       alu_b;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       dmem_rdata;
    logic [xlen-1:0]       wb_data;
    logic                  load_to_dmem;
    logic                  dmem_we;
    logic [pc_w-1:0]       dmem_waddr;
    logic [xlen-1:0]       dmem_wdata;

    assign instr    = imem_rdata;
    assign pc_plus1 = pc + pc_w'(1);
    assign imm_ext  = {{(xlen-16){instr.i_fields.imm[15]}}, instr.i_fields.imm};
    assign alu_b    = ctrl.use_imm ? imm_ext : b_data;
    assign b_idx    = ctrl.b_from_dst ? instr.r_fields.dst : instr.r_fields.src_b;

    // write-back, link first then memory then alu
    assign w_idx   = ctrl.link ? link_reg : instr.r_fields.dst;
    assign wb_data = ctrl.link       ? {{(xlen-pc_w){1'b0}}, pc_plus1} :
                     ctrl.mem_to_reg ? dmem_rdata : alu_result;

    // load port beats a core store
    assign load_to_dmem = load.valid && load.to_data;
    assign dmem_we      = load_to_dmem || ctrl.mem_write;
    assign dmem_waddr   = load_to_dmem ? load.addr : alu_result[pc_w-1:0];
    assign dmem_wdata   = load_to_dmem ? load.data : b_data;

    word_mem #(.depth(mem_depth)) imem (
        .clk(clk), .we(load.valid && !load.to_data), .waddr(load.addr),
        .wdata(load.data), .raddr(pc), .rdata(imem_rdata)
    );

    word_mem #(.depth(mem_depth)) dmem (
        .clk(clk), .we(dmem_we), .waddr(dmem_waddr),
        .wdata(dmem_wdata), .raddr(alu_result[pc_w-1:0]), .rdata(dmem_rdata)
    );

    reg_file u_reg_file (
        .clk(clk), .rst(rst), .a_idx(instr.r_fields.src_a), .b_idx(b_idx),
        .w_idx(w_idx), .we(ctrl.reg_write), .wdata(wb_data),
        .a_data(a_data), .b_data(b_data)
    );

    decoder u_decoder (.rst(rst), .instr(instr), .ctrl(ctrl), .alu_op(alu_op));

    alu u_alu (
        .a(a_data), .b(alu_b), .shamt(instr.r_fields.shamt),
        .op(alu_op), .result(alu_result)
    );

    pc_unit u_pc_unit (
        .clk(clk), .rst(rst), .jump(ctrl.jump), .branch(ctrl.branch),
        .taken(alu_result[0]), .target(instr.j_fields.target[pc_w-1:0]),
        .offset(instr.i_fields.imm), .pc(pc)
    );

endmodule

//--- tb_checker.sv
// models the core from its port activity alone, so it must see every load write from time zero
`timescale 1ns/1ps

module tb_checker import cpu_pkg::*; (
    input logic            clk,
    input logic            rst,
    input load_req_t       load,
    input logic [xlen-1:0] a_data
);

    logic [xlen-1:0] regs [32];
    logic [xlen-1:0] imem_m [1024];
    logic [xlen-1:0] dmem_m [1024];
    logic [pc_w-1:0] pc_m;
    logic [xlen-1:0] word;
    logic [xlen-1:0] exp_a;
    int              errors = 0;
    int              checks = 0;

    // one instruction against the model state
    function automatic void execute(input logic [xlen-1:0] w);
        logic [4:0]      d;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] s;
        logic [xlen-1:0] imm;
        logic [63:0]     prod;
        logic [pc_w-1:0] next_pc;
        logic            taken;
        d       = w[25:21];
        a       = regs[w[20:16]];
        b       = regs[w[15:11]];
        s       = regs[d]; // second source of sw and branches
        imm     = {{16{w[15]}}, w[15:0]};
        prod    = {{32{a[31]}}, a} * {{32{b[31]}}, b}; // low 64 bits equal the signed product
        next_pc = pc_m + 10'd1;
        taken   = 1'b0;
        case (w[31:26])
            op_rtype: begin
                case (w[5:0])
                    6'd0:    regs[d] = a + b;
                    6'd1:    regs[d] = a - b;
                    6'd2:    regs[d] = a & b;
                    6'd3:    regs[d] = a | b;
                    6'd4:    regs[d] = ~a;
                    6'd5:    regs[d] = a ^ b;
                    6'd8:    regs[d] = {31'd0, $signed(a) < $signed(b)};
                    6'd9:    regs[d] = a << w[10:6];
                    6'd10:   regs[d] = a >> w[10:6];
                    6'd11:   regs[d] = prod[63:32];
                    6'd12:   regs[d] = prod[31:0];
                    default: regs[d] = 32'hdeadbeef;
                endcase
            end
            op_addi: regs[d] = a + imm;
            op_andi: regs[d] = a & imm;
            op_ori:  regs[d] = a | imm;
            op_xori: regs[d] = a ^ imm;
            op_lw:   regs[d] = dmem_m[a[9:0] + imm[9:0]];
            op_sw:   dmem_m[a[9:0] + imm[9:0]] = s;
            op_slti: regs[d] = {31'd0, $signed(a) < $signed(imm)};
            op_seq:  regs[d] = {31'd0, a == imm};
            op_lui:  regs[d] = {imm[15:0], 16'd0};
            op_beq:  taken = (a == s);
            op_bne:  taken = (a != s);
            op_bgt:  taken = ($signed(a) > $signed(s));
            op_bge:  taken = ($signed(a) >= $signed(s));
            op_blt:  taken = ($signed(a) < $signed(s));
            op_ble:  taken = ($signed(a) <= $signed(s));
            op_j:    next_pc = w[9:0];
            op_jal: begin
                regs[link_reg] = {22'd0, next_pc}; // return address is PC+1
                next_pc = w[9:0];
            end
            default: taken = 1'b0; // no-op
        endcase
        if (taken) begin
            next_pc = next_pc + imm[9:0];
        end
        pc_m = next_pc;
    endfunction

    // values seen here are those of the cycle that this edge ends
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] = '0;
            end
            pc_m = '0;
        end else begin
            word  = imem_m[pc_m];
            exp_a = regs[word[20:16]];
            checks++;
            if (a_data !== exp_a) begin
                errors++;
                $display("MISMATCH at %0t: pc %0d expected %h got %h", $time, pc_m, exp_a, a_data);
            end
            execute(word);
        end
        if (load.valid) begin // after the core step, so a load beats a store
            if (load.to_data) begin
                dmem_m[load.addr] = load.data;
            end else begin
                imem_m[load.addr] = load.data;
            end
        end
    end

endmodule

//--- tb_cpu.sv
// programs end in a jump to self; every test reloads imem under reset and leaves old data words
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

    localparam logic [5:0] op_nop = 6'd63; // unused opcode, PC+1 only
    localparam int load_dir  = 64;  // words per directed test, data included
    localparam int load_rand = 240;
    localparam int run_dir   = 90;
    localparam int run_rand  = 240;
    localparam int cycle_limit = 4 * (load_dir + 5 + run_dir) + (5 + run_dir)
                               + 2 * (load_rand + 5 + run_rand) + 100;

    logic            clk;
    logic            rst;
    load_req_t       load;
    logic [xlen-1:0] a_data;
    logic [31:0]     prog [$];
    int              data_addr [$];
    logic [31:0]     data_word [$];
    logic [31:0]     rng;
    int              cycles = 0;
    logic [5:0]      r_funcs [11] = '{fn_add, fn_sub, fn_and, fn_or, fn_not, fn_xor,
                                      fn_slt, fn_sll, fn_srl, fn_mul_hi, fn_mul_lo};
    logic [5:0]      imm_ops [7] = '{op_addi, op_andi, op_ori, op_xori, op_slti, op_seq, op_lui};

    cpu_top #(.mem_depth(1024)) DUT (.clk(clk), .rst(rst), .load(load), .a_data(a_data));

    tb_checker u_checker (.clk(clk), .rst(rst), .load(load), .a_data(a_data));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: simulation did not finish");
            $display("checks: %0d, errors: %0d", u_checker.checks, u_checker.errors);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [31:0] rw(logic [5:0] fn, int d, int a, int b, int sh);
        return {op_rtype, d[4:0], a[4:0], b[4:0], sh[4:0], fn};
    endfunction

    function automatic logic [31:0] iw(logic [5:0] op, int d, int a, int imm);
        return {op, d[4:0], a[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] jw(logic [5:0] op, int target);
        return {op, target[25:0]};
    endfunction

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] random_instr();
        int          sel;
        logic [31:0] r;
        sel = int'(next_rand() % 32'd18);
        r   = next_rand();
        if (sel < 11) begin
            return rw(r_funcs[sel], int'(r[4:0]), int'(r[9:5]), int'(r[14:10]), int'(r[19:15]));
        end
        return iw(imm_ops[sel - 11], int'(r[4:0]), int'(r[9:5]), int'(r[31:16]));
    endfunction

    function automatic void put(logic [31:0] w);
        prog.push_back(w);
    endfunction

    // no-ops that show every register on a_data, then park the PC
    function automatic void finish_program();
        for (int r = 0; r < 32; r++) begin
            put(iw(op_nop, 0, r, 0));
        end
        put(jw(op_j, prog.size()));
    endfunction

    task automatic drive_load(logic to_data, int addr, logic [31:0] data);
        load.valid   = 1'b1;
        load.to_data = to_data;
        load.addr    = addr[9:0];
        load.data    = data;
        @(posedge clk);
        #1;
        load.valid = 1'b0;
    endtask

    task automatic load_program();
        rst = 1'b1;
        foreach (prog[i]) drive_load(1'b0, i, prog[i]);
        foreach (data_addr[i]) drive_load(1'b1, data_addr[i], data_word[i]);
        prog.delete();
        data_addr.delete();
        data_word.delete();
    endtask

    task automatic release_reset();
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0; // address 0 runs in this cycle
    endtask

    task automatic run_cycles(int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic run_program(int n);
        load_program();
        release_reset();
        run_cycles(n);
    endtask

    initial begin
        rst  = 1'b1;
        load = '0;
        rng  = 32'd15110;
        @(posedge clk);
        #1;
        // immediates and R-type
        put(iw(op_addi, 1, 0, -7));
        put(iw(op_addi, 2, 0, 300));
        put(iw(op_lui, 5, 0, 'h8001));
        put(iw(op_ori, 6, 1, 'h0f0));
        put(iw(op_andi, 7, 2, -4));
        put(iw(op_xori, 8, 1, 'h5555));
        put(iw(op_slti, 9, 1, -6));
        put(iw(op_seq, 10, 2, 300));
        put(rw(fn_add, 11, 1, 2, 0));
        put(rw(fn_sub, 12, 1, 2, 0));
        put(rw(fn_and, 13, 5, 1, 0));
        put(rw(fn_or, 14, 1, 2, 0));
        put(rw(fn_not, 15, 1, 0, 0));
        put(rw(fn_xor, 16, 1, 5, 0));
        put(rw(fn_slt, 17, 1, 2, 0));
        put(rw(fn_sll, 18, 2, 0, 4));
        put(rw(fn_srl, 19, 1, 0, 3));
        put(rw(fn_mul_lo, 20, 1, 5, 0));
        put(rw(fn_mul_hi, 21, 1, 5, 0));
        put(rw(6'd6, 22, 1, 2, 0)); // unknown func
        finish_program();
        run_program(run_dir);
        // loads, store then load, and a port write racing a store
        data_addr.push_back(10);
        data_word.push_back(32'hcafef00d);
        data_addr.push_back(11);
        data_word.push_back(32'hfffffffe);
        put(iw(op_addi, 1, 0, 10));
        put(iw(op_lw, 2, 1, 0));
        put(iw(op_lw, 4, 1, 1));
        put(iw(op_addi, 5, 0, 77));
        put(iw(op_sw, 5, 0, 20));
        put(iw(op_lw, 6, 0, 20));
        put(iw(op_sw, 5, 0, 21));   // pc 6, clashes with the port write
        put(iw(op_lw, 7, 0, 21));
        finish_program();
        load_program();
        release_reset();
        run_cycles(6);
        drive_load(1'b1, 21, 32'h1234abcd);
        run_cycles(run_dir);
        // branches, a skipped write marks a taken one
        put(iw(op_addi, 1, 0, 5));
        put(iw(op_addi, 2, 0, 5));
        put(iw(op_addi, 4, 0, -3));
        put(iw(op_beq, 2, 1, 1));
        put(iw(op_addi, 10, 0, 1));
        put(iw(op_bne, 2, 1, 1));
        put(iw(op_addi, 11, 0, 1));
        put(iw(op_bgt, 4, 1, 1));
        put(iw(op_addi, 12, 0, 1));
        put(iw(op_bge, 1, 4, 1));
        put(iw(op_addi, 13, 0, 1));
        put(iw(op_blt, 1, 4, 1));
        put(iw(op_addi, 14, 0, 1));
        put(iw(op_ble, 2, 1, 1));
        put(iw(op_addi, 15, 0, 1));
        put(iw(op_beq, 4, 1, 1));   // 5 against -3, falls through
        put(iw(op_addi, 16, 0, 1));
        put(iw(op_bne, 4, 1, 1));
        put(iw(op_addi, 17, 0, 1));
        put(iw(op_bgt, 1, 4, 1));   // -3 against 5, falls through
        put(iw(op_addi, 18, 0, 1));
        put(iw(op_bge, 2, 1, 1));
        put(iw(op_addi, 19, 0, 1));
        put(iw(op_ble, 4, 1, 1));   // 5 against -3, falls through
        put(iw(op_addi, 20, 0, 1));
        put(iw(op_addi, 6, 6, 1));
        put(iw(op_blt, 1, 6, -2)); // loop back until r6 reaches r1
        finish_program();
        run_program(run_dir);
        // jumps, link and a reset in mid-run
        put(iw(op_addi, 1, 1, 1));
        put(jw(op_jal, 4));
        put(iw(op_addi, 20, 0, 9));
        put(iw(op_addi, 21, 0, 9));
        put(iw(op_nop, 0, 3, 0));
        put(jw(op_j, 7));
        put(iw(op_addi, 22, 0, 9));
        finish_program();
        run_program(20);
        release_reset();
        run_cycles(run_dir);
        // random straight-line programs
        repeat (2) begin
            repeat (200) put(random_instr());
            finish_program();
            run_program(run_rand);
        end
        $display("checks: %0d, errors: %0d", u_checker.checks, u_checker.errors);
        if (u_checker.errors == 0 && u_checker.checks > 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- cpu_top.f
cpu_pkg.sv
word_mem.sv
reg_file.sv
alu.sv
decoder.sv
pc_unit.sv
cpu_top.sv
tb_checker.sv
tb_cpu.sv

//--- run.sh
#!/bin/sh
# builds tb_cpu with Verilator and runs it; the log decides pass or fail

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --top-module tb_cpu -f cpu_top.f -o sim_tb_cpu
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb_cpu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "test failed"
    exit 1
fi

echo "test passed"
exit 0
